// ==== rtl/edge_pkg.sv ====
package edge_pkg;

    localparam int NODE_W     = 7;
    localparam int LANE_W     = 8;
    localparam int NUM_LANES  = 2;
    localparam int SUM_W      = 12;  // holds MAX_DEGREE full-scale lanes
    localparam int MAX_DEGREE = 8;
    localparam int DEG_W      = 4;

    typedef logic [NODE_W-1:0] node_id_t;

    typedef struct packed {
        node_id_t node;
    } task_t;

    typedef struct packed {
        node_id_t                         node;
        logic [DEG_W-1:0]                 degree;
        logic [NUM_LANES-1:0][SUM_W-1:0]  sum;
    } result_t;

    typedef enum logic {
        BUS_NEIGHBOR = 1'b0,
        BUS_FEATURE  = 1'b1
    } bus_kind_t;

    typedef enum logic [1:0] {
        LOAD_DEGREE   = 2'd0,
        LOAD_NEIGHBOR = 2'd1,
        LOAD_FEATURE  = 2'd2
    } load_sel_t;

    // two ids in the low bits, or lane 1 over lane 0
    typedef logic [NUM_LANES*LANE_W-1:0] bus_data_t;

endpackage

// ==== rtl/graph_bus_if.sv ====
`timescale 1ns/10ps

interface graph_bus_if import edge_pkg::*; ();

    logic             req;
    bus_kind_t        kind;
    node_id_t         node;
    logic             grant;       // one-cycle pulse
    logic             rsp_valid;
    logic             rsp_last;
    bus_data_t        rsp_data;
    logic [DEG_W-1:0] rsp_degree;

    modport pe (
        output req, kind, node,
        input  grant, rsp_valid, rsp_last, rsp_data, rsp_degree
    );

    modport arb (
        input  req, kind, node,
        output grant, rsp_valid, rsp_last, rsp_data, rsp_degree
    );

endinterface

// ==== rtl/credit_queue.sv ====
`timescale 1ns/10ps

module credit_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] wrap_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop);  // full queue still takes a push with a pop
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wrap_inc(wr_ptr);
            if (do_pop) rd_ptr <= wrap_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== rtl/edge_pe.sv ====
`timescale 1ns/10ps

module edge_pe import edge_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    task_valid,
    input  task_t   task_in,
    output logic    idle,
    graph_bus_if.pe bus,
    output logic    done,
    output result_t result,
    input  logic    result_accept
);
    localparam int SLOT_W = $clog2(MAX_DEGREE);

    typedef enum logic [2:0] {
        S_IDLE,
        S_NBR_REQ,
        S_NBR_STREAM,
        S_FEAT_REQ,
        S_FEAT_WAIT,
        S_DONE
    } state_t;

    state_t                          state;
    node_id_t                        target;
    logic [DEG_W-1:0]                degree;
    node_id_t                        nbr_ids [MAX_DEGREE];
    logic [SLOT_W-1:0]               wr_slot;   // next free neighbor slot
    logic [SLOT_W-1:0]               feat_idx;  // neighbor being fetched
    logic [NUM_LANES-1:0][SUM_W-1:0] sums;
    logic                            last_feat;

    assign idle      = (state == S_IDLE);
    assign done      = (state == S_DONE);
    assign last_feat = (DEG_W'(feat_idx) + 1'b1) == degree;

    // request lines follow the state, so req holds until grant
    assign bus.req  = (state == S_NBR_REQ) || (state == S_FEAT_REQ);
    assign bus.kind = (state == S_FEAT_REQ) ? BUS_FEATURE : BUS_NEIGHBOR;
    assign bus.node = (state == S_FEAT_REQ) ? nbr_ids[feat_idx] : target;

    assign result = '{node: target, degree: degree, sum: sums};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            wr_slot  <= '0;
            feat_idx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (task_valid) state <= S_NBR_REQ;
                end
                S_NBR_REQ: begin
                    if (bus.grant) begin
                        state   <= S_NBR_STREAM;
                        wr_slot <= '0;
                    end
                end
                S_NBR_STREAM: begin
                    if (bus.rsp_valid) begin
                        wr_slot <= wr_slot + SLOT_W'(2);
                        if (bus.rsp_last) begin
                            feat_idx <= '0;
                            // no neighbors means nothing to sum
                            state    <= (bus.rsp_degree == '0) ? S_DONE : S_FEAT_REQ;
                        end
                    end
                end
                S_FEAT_REQ: begin
                    if (bus.grant) state <= S_FEAT_WAIT;
                end
                S_FEAT_WAIT: begin
                    if (bus.rsp_valid) begin
                        feat_idx <= feat_idx + 1'b1;
                        state    <= last_feat ? S_DONE : S_FEAT_REQ;
                    end
                end
                S_DONE: begin
                    if (result_accept) state <= S_IDLE;  // held while result queue is full
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && task_valid) begin
            target <= task_in.node;
            sums   <= '0;
        end
        if (state == S_NBR_STREAM && bus.rsp_valid) begin
            nbr_ids[wr_slot]        <= bus.rsp_data[NODE_W-1:0];
            nbr_ids[wr_slot + 1'b1] <= bus.rsp_data[2*NODE_W-1:NODE_W];
            degree                  <= bus.rsp_degree;
        end
        if (state == S_FEAT_WAIT && bus.rsp_valid) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                sums[l] <= sums[l] + SUM_W'(bus.rsp_data[l*LANE_W +: LANE_W]);
            end
        end
    end

endmodule

// ==== rtl/graph_bus_arbiter.sv ====
`timescale 1ns/10ps

module graph_bus_arbiter import edge_pkg::*; #(
    parameter int NUM_PE = 2
) (
    input  logic             clk,
    input  logic             reset,
    graph_bus_if.arb         pes [NUM_PE],
    output logic             rd_en,
    output bus_kind_t        rd_kind,
    output node_id_t         rd_node,
    input  logic             rsp_valid,
    input  logic             rsp_last,
    input  bus_data_t        rsp_data,
    input  logic [DEG_W-1:0] rsp_degree
);
    localparam int IDX_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

    logic [NUM_PE-1:0] req_vec;
    logic [NUM_PE-1:0] grant_q;
    bus_kind_t         kind_vec [NUM_PE];
    node_id_t          node_vec [NUM_PE];
    logic [IDX_W-1:0]  owner;
    logic [IDX_W-1:0]  prio;   // first index looked at
    logic [IDX_W-1:0]  pick;
    logic              pick_found;
    logic              busy;

    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        assign req_vec[i]        = pes[i].req;
        assign kind_vec[i]       = pes[i].kind;
        assign node_vec[i]       = pes[i].node;
        assign pes[i].grant      = grant_q[i];
        assign pes[i].rsp_valid  = rsp_valid && (owner == IDX_W'(i));
        assign pes[i].rsp_last   = rsp_last && (owner == IDX_W'(i));
        assign pes[i].rsp_data   = rsp_data;
        assign pes[i].rsp_degree = rsp_degree;
    end

    always_comb begin
        pick       = prio;
        pick_found = 1'b0;
        for (int k = 0; k < NUM_PE; k++) begin
            if (!pick_found && req_vec[(int'(prio) + k) % NUM_PE]) begin
                pick       = IDX_W'((int'(prio) + k) % NUM_PE);
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            owner   <= '0;
            prio    <= '0;
            grant_q <= '0;
            rd_en   <= 1'b0;
        end else begin
            grant_q <= '0;
            rd_en   <= 1'b0;
            if (busy && rsp_valid && rsp_last) begin
                busy <= 1'b0;
            end else if (!busy && pick_found) begin
                busy    <= 1'b1;
                owner   <= pick;
                grant_q <= NUM_PE'(1) << pick;
                rd_en   <= 1'b1;
                prio    <= (pick == IDX_W'(NUM_PE - 1)) ? '0 : pick + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && pick_found) begin
            rd_kind <= kind_vec[pick];
            rd_node <= node_vec[pick];
        end
    end

endmodule

// ==== rtl/graph_mem.sv ====
`timescale 1ns/10ps

module graph_mem import edge_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load_en,
    input  load_sel_t                     load_sel,
    input  node_id_t                      load_node,
    input  logic [$clog2(MAX_DEGREE)-1:0] load_index,
    input  bus_data_t                     load_data,
    input  logic                          rd_en,
    input  bus_kind_t                     rd_kind,
    input  node_id_t                      rd_node,
    output logic                          rsp_valid,
    output logic                          rsp_last,
    output bus_data_t                     rsp_data,
    output logic [DEG_W-1:0]              rsp_degree
);
    localparam int NUM_NODES = 2 ** NODE_W;
    localparam int SLOT_W    = $clog2(MAX_DEGREE);

    logic [DEG_W-1:0]  degree_tab [NUM_NODES];
    node_id_t          nbr_tab    [NUM_NODES][MAX_DEGREE];
    bus_data_t         feat_tab   [NUM_NODES];

    logic              active;      // neighbor stream past its first beat
    node_id_t          cur_node;
    logic [SLOT_W-1:0] slot;        // first slot of the next beat
    logic [DEG_W-1:0]  beats_left;
    node_id_t          sel_node;
    logic [SLOT_W-1:0] sel_slot;
    logic [DEG_W-1:0]  sel_deg;
    logic [DEG_W-1:0]  sel_left;
    logic              nbr_beat;
    logic              feat_beat;

    assign sel_node  = active ? cur_node : rd_node;
    assign sel_slot  = active ? slot : '0;
    assign sel_deg   = degree_tab[sel_node];
    // at least one beat, even for degree zero
    assign sel_left  = active ? beats_left :
                       (sel_deg == '0) ? DEG_W'(1) : (sel_deg + 1'b1) >> 1;
    assign nbr_beat  = active || (rd_en && rd_kind == BUS_NEIGHBOR);
    assign feat_beat = rd_en && rd_kind == BUS_FEATURE;

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            slot       <= '0;
            beats_left <= '0;
            rsp_valid  <= 1'b0;
            rsp_last   <= 1'b0;
        end else begin
            rsp_valid <= nbr_beat || feat_beat;
            rsp_last  <= (nbr_beat && sel_left == DEG_W'(1)) || feat_beat;
            if (nbr_beat) begin
                active     <= (sel_left != DEG_W'(1));
                slot       <= sel_slot + SLOT_W'(2);
                beats_left <= sel_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (nbr_beat) begin
            cur_node   <= sel_node;
            rsp_degree <= sel_deg;
            rsp_data   <= bus_data_t'({nbr_tab[sel_node][sel_slot + 1'b1],
                                       nbr_tab[sel_node][sel_slot]});
        end else if (feat_beat) begin
            rsp_data <= feat_tab[rd_node];
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            case (load_sel)
                LOAD_DEGREE:   degree_tab[load_node] <= load_data[DEG_W-1:0];
                LOAD_NEIGHBOR: nbr_tab[load_node][load_index] <= load_data[NODE_W-1:0];
                LOAD_FEATURE:  feat_tab[load_node] <= load_data;
                default:       ;
            endcase
        end
    end

endmodule

// ==== rtl/task_dispatch.sv ====
`timescale 1ns/10ps

module task_dispatch import edge_pkg::*; #(
    parameter int NUM_PE     = 2,
    parameter int TASK_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              task_valid,
    input  node_id_t          task_node,
    output logic              task_credit,
    input  logic [NUM_PE-1:0] pe_idle,
    output logic [NUM_PE-1:0] pe_task_valid,
    output task_t             pe_task
);
    task_t             new_task;
    task_t             head;
    logic              q_not_empty;
    logic              pop;
    logic [NUM_PE-1:0] avail;
    logic [NUM_PE-1:0] sel;

    assign new_task.node = task_node;
    assign avail = pe_idle & ~pe_task_valid;  // PE handed a task last cycle still shows idle
    assign sel   = avail & -avail;            // lowest idle PE
    assign pop   = q_not_empty && (|avail);

    credit_queue #(
        .payload_t (task_t),
        .DEPTH     (TASK_DEPTH)
    ) u_task_q (
        .clk       (clk),
        .reset     (reset),
        .push      (task_valid),
        .push_data (new_task),
        .pop       (pop),
        .head      (head),
        .not_empty (q_not_empty),
        .full      ()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            task_credit   <= 1'b0;
            pe_task_valid <= '0;
        end else begin
            task_credit   <= pop;
            pe_task_valid <= pop ? sel : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) pe_task <= head;
    end

endmodule

// ==== rtl/result_port.sv ====
`timescale 1ns/10ps

module result_port import edge_pkg::*; #(
    parameter int NUM_PE         = 2,
    parameter int RESULT_CREDITS = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [NUM_PE-1:0] pe_done,
    input  result_t           pe_result [NUM_PE],
    output logic [NUM_PE-1:0] pe_accept,
    input  logic              result_credit,
    output logic              result_valid,
    output node_id_t          result_node,
    output logic [DEG_W-1:0]  result_degree,
    output logic [SUM_W-1:0]  result_sum0,
    output logic [SUM_W-1:0]  result_sum1
);
    localparam int CRED_W = $clog2(RESULT_CREDITS + 1);

    logic [NUM_PE-1:0] rr_mask;   // PEs above the last one accepted
    logic [NUM_PE-1:0] upper;
    logic [NUM_PE-1:0] pick_vec;
    logic [CRED_W-1:0] credits;
    logic              push;
    logic              q_not_empty;
    logic              q_full;
    result_t           push_data;
    result_t           head;

    assign upper     = pe_done & rr_mask;
    assign pick_vec  = (|upper) ? (upper & -upper) : (pe_done & -pe_done);
    assign pe_accept = q_full ? '0 : pick_vec;
    assign push      = |pe_accept;

    always_comb begin
        push_data = '0;
        for (int i = 0; i < NUM_PE; i++) begin
            if (pick_vec[i]) push_data = pe_result[i];
        end
    end

    credit_queue #(
        .payload_t (result_t),
        .DEPTH     (RESULT_CREDITS)
    ) u_result_q (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (result_valid),
        .head      (head),
        .not_empty (q_not_empty),
        .full      (q_full)
    );

    // one result per cycle while a credit is held
    assign result_valid  = q_not_empty && (credits != '0);
    assign result_node   = head.node;
    assign result_degree = head.degree;
    assign result_sum0   = head.sum[0];
    assign result_sum1   = head.sum[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CRED_W'(RESULT_CREDITS);
            rr_mask <= '1;
        end else begin
            credits <= credits + CRED_W'(result_credit) - CRED_W'(result_valid);
            if (push) rr_mask <= ~((pick_vec << 1) - 1'b1);
        end
    end

endmodule

// ==== rtl/gnn_edge_cluster.sv ====
`timescale 1ns/10ps

module gnn_edge_cluster import edge_pkg::*; #(
    parameter int NUM_PE         = 2,
    parameter int TASK_DEPTH     = 4,
    parameter int RESULT_CREDITS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          task_valid,
    input  node_id_t                      task_node,
    output logic                          task_credit,
    output logic                          result_valid,
    output node_id_t                      result_node,
    output logic [DEG_W-1:0]              result_degree,
    output logic [SUM_W-1:0]              result_sum0,
    output logic [SUM_W-1:0]              result_sum1,
    input  logic                          result_credit,
    input  logic                          load_en,
    input  load_sel_t                     load_sel,
    input  node_id_t                      load_node,
    input  logic [$clog2(MAX_DEGREE)-1:0] load_index,
    input  bus_data_t                     load_data
);
    logic [NUM_PE-1:0] pe_idle;
    logic [NUM_PE-1:0] pe_task_valid;
    task_t             pe_task;
    logic [NUM_PE-1:0] pe_done;
    result_t           pe_result [NUM_PE];
    logic [NUM_PE-1:0] pe_accept;
    logic              rd_en;
    bus_kind_t         rd_kind;
    node_id_t          rd_node;
    logic              mem_rsp_valid;
    logic              mem_rsp_last;
    bus_data_t         mem_rsp_data;
    logic [DEG_W-1:0]  mem_rsp_degree;

    graph_bus_if bus [NUM_PE] ();

    task_dispatch #(
        .NUM_PE     (NUM_PE),
        .TASK_DEPTH (TASK_DEPTH)
    ) u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .task_valid    (task_valid),
        .task_node     (task_node),
        .task_credit   (task_credit),
        .pe_idle       (pe_idle),
        .pe_task_valid (pe_task_valid),
        .pe_task       (pe_task)
    );

    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        edge_pe u_pe (
            .clk           (clk),
            .reset         (reset),
            .task_valid    (pe_task_valid[i]),
            .task_in       (pe_task),
            .idle          (pe_idle[i]),
            .bus           (bus[i]),
            .done          (pe_done[i]),
            .result        (pe_result[i]),
            .result_accept (pe_accept[i])
        );
    end

    graph_bus_arbiter #(
        .NUM_PE (NUM_PE)
    ) u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .pes        (bus),
        .rd_en      (rd_en),
        .rd_kind    (rd_kind),
        .rd_node    (rd_node),
        .rsp_valid  (mem_rsp_valid),
        .rsp_last   (mem_rsp_last),
        .rsp_data   (mem_rsp_data),
        .rsp_degree (mem_rsp_degree)
    );

    graph_mem u_mem (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .load_sel   (load_sel),
        .load_node  (load_node),
        .load_index (load_index),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_kind    (rd_kind),
        .rd_node    (rd_node),
        .rsp_valid  (mem_rsp_valid),
        .rsp_last   (mem_rsp_last),
        .rsp_data   (mem_rsp_data),
        .rsp_degree (mem_rsp_degree)
    );

    result_port #(
        .NUM_PE         (NUM_PE),
        .RESULT_CREDITS (RESULT_CREDITS)
    ) u_result (
        .clk           (clk),
        .reset         (reset),
        .pe_done       (pe_done),
        .pe_result     (pe_result),
        .pe_accept     (pe_accept),
        .result_credit (result_credit),
        .result_valid  (result_valid),
        .result_node   (result_node),
        .result_degree (result_degree),
        .result_sum0   (result_sum0),
        .result_sum1   (result_sum1)
    );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;  // released between edges
    end

endmodule

// ==== bench/result_port_properties.sv ====
`timescale 1ns/10ps

module result_port_properties #(
    parameter int RESULT_CREDITS = 4
) (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  result_valid,
    input logic                                  result_credit,
    input logic [$clog2(RESULT_CREDITS + 1)-1:0] credits,
    input logic                                  push
);
    localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

    logic [CNT_W-1:0] held;   // credits as seen at the port
    logic [CNT_W-1:0] fill;   // results waiting in the queue
    int               assert_errors = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= CNT_W'(RESULT_CREDITS);
            fill <= '0;
        end else begin
            held <= held + CNT_W'(result_credit) - CNT_W'(result_valid);
            fill <= fill + CNT_W'(push) - CNT_W'(result_valid);
        end
    end

    // a result only leaves against a held credit
    valid_needs_credit: assert property (
        @(posedge clk) disable iff (reset) result_valid |-> held != '0
    ) else begin
        assert_errors++;
        $error("result_valid high while no result credit is held");
    end

    credit_bound: assert property (
        @(posedge clk) disable iff (reset) credits <= RESULT_CREDITS
    ) else begin
        assert_errors++;
        $error("result credit count above its reset value");
    end

    // pop is result_valid
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
            push && fill == CNT_W'(RESULT_CREDITS) |-> result_valid
    ) else begin
        assert_errors++;
        $error("push into a full result queue with no pop");
    end

endmodule

// ==== bench/tb_gnn_edge_cluster.sv ====
`timescale 1ns/10ps

module tb_gnn_edge_cluster import edge_pkg::*; ();

    localparam int NUM_PE         = 2;
    localparam int TASK_DEPTH     = 4;
    localparam int RESULT_CREDITS = 4;
    localparam int NUM_NODES      = 2 ** NODE_W;
    localparam int NUM_TARGETS    = 24;  // targets are nodes 0 .. NUM_TARGETS-1
    localparam int SLOT_W         = $clog2(MAX_DEGREE);
    localparam int CYCLE_LIMIT    = 200 * NUM_TARGETS + 500;

    logic               clk;
    logic               reset;
    logic               task_valid;
    node_id_t           task_node;
    logic               task_credit;
    logic               result_valid;
    node_id_t           result_node;
    logic [DEG_W-1:0]   result_degree;
    logic [SUM_W-1:0]   result_sum0;
    logic [SUM_W-1:0]   result_sum1;
    logic               result_credit;
    logic               load_en;
    load_sel_t          load_sel;
    node_id_t           load_node;
    logic [SLOT_W-1:0]  load_index;
    bus_data_t          load_data;

    // testbench copy of the graph
    int                 deg_tab  [NUM_TARGETS];
    node_id_t           nbr_tab  [NUM_TARGETS][MAX_DEGREE];
    bus_data_t          feat_tab [NUM_NODES];

    bit                 pending [NUM_NODES];
    int unsigned        lcg_state    = 29170;
    int                 task_credits = TASK_DEPTH;
    int                 credits_owed = 0;
    bit                 hold_credits = 1'b0;
    int                 results_seen = 0;
    int                 checks       = 0;
    int                 error_count  = 0;
    int                 cycles       = 0;

    clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(8)) u_clk (.clk(clk), .reset(reset));

    gnn_edge_cluster #(
        .NUM_PE         (NUM_PE),
        .TASK_DEPTH     (TASK_DEPTH),
        .RESULT_CREDITS (RESULT_CREDITS)
    ) dut0 (.*);

    bind result_port result_port_properties #(
        .RESULT_CREDITS (RESULT_CREDITS)
    ) u_props (
        .clk           (clk),
        .reset         (reset),
        .result_valid  (result_valid),
        .result_credit (result_credit),
        .credits       (credits),
        .push          (push)
    );

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    function automatic result_t expected_result(input node_id_t target);
        result_t   r;
        bus_data_t f;
        r.node   = target;
        r.degree = DEG_W'(deg_tab[target]);
        r.sum    = '0;
        for (int k = 0; k < deg_tab[target]; k++) begin
            f = feat_tab[nbr_tab[target][k]];
            for (int l = 0; l < NUM_LANES; l++) begin
                r.sum[l] = r.sum[l] + SUM_W'(f[l*LANE_W +: LANE_W]);
            end
        end
        return r;
    endfunction

    task automatic check_degree(input node_id_t node, input logic [DEG_W-1:0] got,
                                input logic [DEG_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t: node %0d degree %0d, expected %0d", $time, node, got, exp);
        end
    endtask

    task automatic check_sums(input node_id_t node,
                              input logic [NUM_LANES-1:0][SUM_W-1:0] got,
                              input logic [NUM_LANES-1:0][SUM_W-1:0] exp);
        for (int l = 0; l < NUM_LANES; l++) begin
            checks++;
            if (got[l] !== exp[l]) begin
                error_count++;
                $display("[FAIL] %0t: node %0d lane %0d sum %0d, expected %0d",
                         $time, node, l, got[l], exp[l]);
            end
        end
    endtask

    task automatic check_result(input result_t got, input result_t exp);
        check_degree(got.node, got.degree, exp.degree);
        check_sums(got.node, got.sum, exp.sum);
    endtask

    task automatic write_mem(input load_sel_t sel, input node_id_t node, input int idx,
                             input bus_data_t data);
        load_en    = 1'b1;
        load_sel   = sel;
        load_node  = node;
        load_index = SLOT_W'(idx);
        load_data  = data;
        @(negedge clk);
        load_en    = 1'b0;
    endtask

    task automatic send_task(input node_id_t node);
        while (task_credits == 0) @(negedge clk);
        task_valid = 1'b1;
        task_node  = node;
        task_credits--;
        pending[node] = 1'b1;
        @(negedge clk);
        task_valid = 1'b0;  // next call may raise it again at once
    endtask

    task automatic wait_results(input int n);
        while (results_seen < n) @(negedge clk);
    endtask

    // result checks and credit return
    always @(negedge clk) begin : compare_results
        result_t got;
        if (!reset && task_credit) begin
            task_credits++;
            if (task_credits > TASK_DEPTH) begin
                error_count++;
                $display("ERROR: task credit count rose to %0d, above the queue depth",
                         task_credits);
            end
        end
        if (!reset && result_valid) begin
            got.node   = result_node;
            got.degree = result_degree;
            got.sum[0] = result_sum0;
            got.sum[1] = result_sum1;
            if (!pending[got.node]) begin
                error_count++;
                $display("ERROR: result for node %0d was not expected or came twice", got.node);
            end else begin
                pending[got.node] = 1'b0;
                check_result(got, expected_result(got.node));
            end
            results_seen++;
            credits_owed++;
        end
        if (!hold_credits && credits_owed > 0) begin
            result_credit = 1'b1;
            credits_owed--;
        end else begin
            result_credit = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles with %0d of %0d results in",
                     cycles, results_seen, NUM_TARGETS);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int base;
        int assert_fails;
        task_valid    = 1'b0;
        task_node     = '0;
        result_credit = 1'b0;
        load_en       = 1'b0;
        load_sel      = LOAD_DEGREE;
        load_node     = '0;
        load_index    = '0;
        load_data     = '0;

        foreach (feat_tab[n]) feat_tab[n] = bus_data_t'(next_rand());
        deg_tab[0] = 3;
        deg_tab[1] = 0;
        deg_tab[2] = 1;
        deg_tab[3] = 2;
        deg_tab[4] = 7;
        deg_tab[5] = MAX_DEGREE;
        for (int t = 6; t < NUM_TARGETS; t++) deg_tab[t] = next_rand() % (MAX_DEGREE + 1);
        foreach (nbr_tab[t, k]) nbr_tab[t][k] = node_id_t'(next_rand());

        while (reset) @(negedge clk);
        if (task_credit !== 1'b0 || result_valid !== 1'b0) begin
            error_count++;
            $display("ERROR: task_credit or result_valid not low after reset");
        end

        for (int n = 0; n < NUM_NODES; n++) write_mem(LOAD_FEATURE, node_id_t'(n), 0, feat_tab[n]);
        for (int t = 0; t < NUM_TARGETS; t++) begin
            write_mem(LOAD_DEGREE, node_id_t'(t), 0, bus_data_t'(deg_tab[t]));
            for (int k = 0; k < MAX_DEGREE; k++) begin
                write_mem(LOAD_NEIGHBOR, node_id_t'(t), k, bus_data_t'(nbr_tab[t][k]));
            end
        end

        // single tasks with degrees 3, 0, 1, 2, 7 and 8
        for (int t = 0; t < 6; t++) begin
            send_task(node_id_t'(t));
            wait_results(t + 1);
        end

        // back-to-back tasks keep both PEs on the bus
        for (int t = 6; t < 14; t++) send_task(node_id_t'(t));
        wait_results(14);
        while (credits_owed > 0) @(negedge clk);
        @(negedge clk);

        // result credits held back
        hold_credits = 1'b1;
        base = results_seen;
        for (int t = 14; t < NUM_TARGETS; t++) send_task(node_id_t'(t));
        wait_results(base + RESULT_CREDITS);
        repeat (300) @(negedge clk);  // window in which nothing else may appear
        if (results_seen - base > RESULT_CREDITS) begin
            error_count++;
            $display("ERROR: %0d results sent with only %0d result credits",
                     results_seen - base, RESULT_CREDITS);
        end
        hold_credits = 1'b0;
        wait_results(NUM_TARGETS);
        repeat (10) @(negedge clk);

        if (task_credits != TASK_DEPTH) begin
            error_count++;
            $display("ERROR: %0d task credits held at the end, expected %0d",
                     task_credits, TASK_DEPTH);
        end
        foreach (pending[n]) begin
            if (pending[n]) begin
                error_count++;
                $display("ERROR: no result came back for node %0d", n);
            end
        end

        assert_fails = dut0.u_result.u_props.assert_errors;
        $display("results %0d, checks %0d, errors %0d, assertion failures %0d",
                 results_seen, checks, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/edge_pkg.sv
rtl/graph_bus_if.sv
rtl/credit_queue.sv
rtl/edge_pe.sv
rtl/graph_bus_arbiter.sv
rtl/graph_mem.sv
rtl/task_dispatch.sv
rtl/result_port.sv
rtl/gnn_edge_cluster.sv
bench/clock_gen.sv
bench/result_port_properties.sv
bench/tb_gnn_edge_cluster.sv

// ==== Bender.yml ====
package:
  name: gnn_edge_cluster

sources:
  - files:
      - rtl/edge_pkg.sv
      - rtl/graph_bus_if.sv
      - rtl/credit_queue.sv
      - rtl/edge_pe.sv
      - rtl/graph_bus_arbiter.sv
      - rtl/graph_mem.sv
      - rtl/task_dispatch.sv
      - rtl/result_port.sv
      - rtl/gnn_edge_cluster.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/result_port_properties.sv
      - bench/tb_gnn_edge_cluster.sv
